// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int data_width_c     = 32;
  localparam int reg_addr_width_c = 5;
  localparam int imm_width_c      = 16;
  localparam int rf_depth_c       = 2 ** reg_addr_width_c; // x0 included.

  typedef enum logic [2:0] {
    op_add  = 3'd0,
    op_sub  = 3'd1,
    op_and  = 3'd2,
    op_xor  = 3'd3,
    op_addi = 3'd4,
    op_li   = 3'd5
  } opcode_e;

  typedef struct packed {
    opcode_e                     opcode;
    logic [reg_addr_width_c-1:0] rd;
    logic [reg_addr_width_c-1:0] rs1;
    logic [reg_addr_width_c-1:0] rs2;
    logic [imm_width_c-1:0]      imm;
  } instr_t;

  typedef struct packed {
    logic                        v;
    logic [reg_addr_width_c-1:0] addr;
  } rf_read_t;

  typedef struct packed {
    logic                        v;
    logic [reg_addr_width_c-1:0] addr;
    logic [data_width_c-1:0]     data;
  } rf_write_t;

  typedef struct packed {
    logic [reg_addr_width_c-1:0] rd;
    logic [data_width_c-1:0]     value;
  } result_t;

endpackage

`default_nettype wire

// File: logic/rf_mem_2r1w_sync.sv
`timescale 1ns/10ps
`default_nettype none

module rf_mem_2r1w_sync (
  input  logic                                  clk_i,
  input  logic                                  w_v_i,
  input  logic [core_pkg::reg_addr_width_c-1:0] w_addr_i,
  input  logic [core_pkg::data_width_c-1:0]     w_data_i,
  input  logic                                  r0_v_i,
  input  logic [core_pkg::reg_addr_width_c-1:0] r0_addr_i,
  output logic [core_pkg::data_width_c-1:0]     r0_data_o,
  input  logic                                  r1_v_i,
  input  logic [core_pkg::reg_addr_width_c-1:0] r1_addr_i,
  output logic [core_pkg::data_width_c-1:0]     r1_data_o
);

  import core_pkg::*;

  logic [data_width_c-1:0] mem [rf_depth_c]; // contents are undefined at power-up.

  // read data is registered and only moves on a valid read.
  always_ff @(posedge clk_i)
  begin
    if (w_v_i)
    begin
      mem[w_addr_i] <= w_data_i;
    end
    if (r0_v_i)
    begin
      r0_data_o <= mem[r0_addr_i];
    end
    if (r1_v_i)
    begin
      r1_data_o <= mem[r1_addr_i];
    end
  end

endmodule

`default_nettype wire

// File: logic/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  core_pkg::rf_read_t [1:0]                rd_port_i,
  input  core_pkg::rf_write_t                     wr_i,
  output logic [1:0][core_pkg::data_width_c-1:0]  rs_data_o
);

  import core_pkg::*;

  logic                              wr_v_eff;   // write after dropping x0.
  logic [data_width_c-1:0]           wr_data_q;  // last write data kept for forwarding.
  logic [1:0]                        mem_rv;
  logic [1:0][reg_addr_width_c-1:0]  mem_raddr;
  logic [1:0][data_width_c-1:0]      mem_rdata;

  assign wr_v_eff = wr_i.v & (wr_i.addr != '0);

  rf_mem_2r1w_sync mem0 (
    .clk_i     (clk_i),
    .w_v_i     (wr_v_eff),
    .w_addr_i  (wr_i.addr),
    .w_data_i  (wr_i.data),
    .r0_v_i    (mem_rv[0]),
    .r0_addr_i (mem_raddr[0]),
    .r0_data_o (mem_rdata[0]),
    .r1_v_i    (mem_rv[1]),
    .r1_addr_i (mem_raddr[1]),
    .r1_data_o (mem_rdata[1])
  );

  always_ff @(posedge clk_i)
  begin
    wr_data_q <= wr_i.data;
  end

  for (genvar i = 0; i < 2; i++)
  begin : g_port
    logic                        fwd;        // same-cycle write to the read address.
    logic                        is_x0;
    logic                        replace;    // write hits the held address.
    logic                        rv_q;
    logic                        fwd_q;
    logic                        zero_q;
    logic [reg_addr_width_c-1:0] addr_q;
    logic [data_width_c-1:0]     fresh_data;
    logic [data_width_c-1:0]     hold_n;
    logic [data_width_c-1:0]     hold_q;

    assign is_x0   = rd_port_i[i].addr == '0;
    assign fwd     = wr_v_eff & rd_port_i[i].v & (rd_port_i[i].addr == wr_i.addr);
    assign replace = wr_v_eff & (addr_q == wr_i.addr);

    // RAM is left idle on a forwarded read or on x0.
    assign mem_rv[i]    = rd_port_i[i].v & ~fwd & ~is_x0;
    assign mem_raddr[i] = rd_port_i[i].addr;

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
      if (!rst_n_i)
      begin
        rv_q   <= 1'b0;
        fwd_q  <= 1'b0;
        zero_q <= 1'b0;
      end
      else
      begin
        rv_q   <= rd_port_i[i].v;
        fwd_q  <= fwd;
        zero_q <= is_x0;
      end
    end

    assign fresh_data = zero_q ? '0 : (fwd_q ? wr_data_q : mem_rdata[i]);
    assign hold_n     = replace ? wr_i.data : fresh_data;

    always_ff @(posedge clk_i)
    begin
      if (rd_port_i[i].v)
      begin
        addr_q <= rd_port_i[i].addr;
      end
      if (rv_q | replace)
      begin
        hold_q <= hold_n; // refresh keeps stalled operands current.
      end
    end

    assign rs_data_o[i] = rv_q ? fresh_data : hold_q;
  end

endmodule

`default_nettype wire

// File: logic/issue_stage.sv
`timescale 1ns/10ps
`default_nettype none

module issue_stage (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     in_valid_i,
  input  core_pkg::instr_t         in_instr_i,
  input  logic                     stage_free_i,
  output logic                     in_ready_o,
  output core_pkg::rf_read_t [1:0] rd_port_o,
  output logic                     issue_valid_o,
  output core_pkg::instr_t         issue_instr_o
);

  import core_pkg::*;

  logic                             accept;
  logic [1:0]                       need;        // per-port source use.
  logic [1:0][reg_addr_width_c-1:0] src_addr;
  logic [1:0]                       last_v_q;    // regfile holds a known address.
  logic [1:0][reg_addr_width_c-1:0] last_addr_q;

  assign in_ready_o    = stage_free_i;
  assign accept        = in_valid_i & stage_free_i;
  assign issue_valid_o = accept;
  assign issue_instr_o = in_instr_i;

  assign src_addr[0] = in_instr_i.rs1;
  assign src_addr[1] = in_instr_i.rs2;

  always_comb
  begin
    case (in_instr_i.opcode)
      op_add, op_sub, op_and, op_xor: need = 2'b11;
      op_addi:                        need = 2'b01;
      default:                        need = 2'b00; // li reads nothing.
    endcase
  end

  // the held address is not read again since the regfile refresh keeps it current.
  for (genvar i = 0; i < 2; i++)
  begin : g_rd
    assign rd_port_o[i].v    = accept & need[i]
                               & ~(last_v_q[i] & (last_addr_q[i] == src_addr[i]));
    assign rd_port_o[i].addr = src_addr[i];
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      last_v_q <= '0;
    end
    else
    begin
      last_v_q <= last_v_q | {rd_port_o[1].v, rd_port_o[0].v};
    end
  end

  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < 2; i++)
    begin
      if (rd_port_o[i].v)
      begin
        last_addr_q[i] <= src_addr[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/exec_stage.sv
`timescale 1ns/10ps
`default_nettype none

module exec_stage (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   issue_valid_i,
  input  core_pkg::instr_t                       issue_instr_i,
  input  logic [1:0][core_pkg::data_width_c-1:0] rs_data_i,
  input  logic                                   fifo_full_i,
  output logic                                   stage_free_o,
  output core_pkg::rf_write_t                    wr_o,
  output logic                                   push_o,
  output core_pkg::result_t                      result_o
);

  import core_pkg::*;

  logic                    valid_q;
  instr_t                  instr_q;
  logic [data_width_c-1:0] imm_ext;
  logic [data_width_c-1:0] alu_result;

  assign push_o       = valid_q & ~fifo_full_i;
  assign stage_free_o = ~valid_q | push_o; // empty, or draining this cycle.

  assign imm_ext = {{(data_width_c - imm_width_c){instr_q.imm[imm_width_c-1]}}, instr_q.imm};

  always_comb
  begin
    case (instr_q.opcode)
      op_add:  alu_result = rs_data_i[0] + rs_data_i[1];
      op_sub:  alu_result = rs_data_i[0] - rs_data_i[1];
      op_and:  alu_result = rs_data_i[0] & rs_data_i[1];
      op_xor:  alu_result = rs_data_i[0] ^ rs_data_i[1];
      op_addi: alu_result = rs_data_i[0] + imm_ext;
      op_li:   alu_result = imm_ext;
      default: alu_result = '0;
    endcase
  end

  // writeback goes out on the same edge as the push.
  assign wr_o.v    = push_o;
  assign wr_o.addr = instr_q.rd;
  assign wr_o.data = alu_result;

  assign result_o.rd    = instr_q.rd;
  assign result_o.value = alu_result;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      valid_q <= 1'b0;
    end
    else if (stage_free_o)
    begin
      valid_q <= issue_valid_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (issue_valid_i)
    begin
      instr_q <= issue_instr_i; // only reaches here when the stage is free.
    end
  end

endmodule

`default_nettype wire

// File: logic/result_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module result_fifo #(
  parameter int depth_p = 2
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              push_i,
  input  core_pkg::result_t data_i,
  input  logic              out_ready_i,
  output logic              full_o,
  output logic              out_valid_o,
  output core_pkg::result_t out_result_o
);

  import core_pkg::*;

  localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_w_lp = $clog2(depth_p + 1);

  result_t               mem [depth_p];
  logic [ptr_w_lp-1:0]   wr_ptr_q;
  logic [ptr_w_lp-1:0]   rd_ptr_q;
  logic [cnt_w_lp-1:0]   count_q;
  logic [cnt_w_lp-1:0]   count_n;
  logic                  push;
  logic                  pop;

  assign out_valid_o  = count_q != '0;
  assign out_result_o = mem[rd_ptr_q];

  assign push = push_i & ~full_o;        // a push is ignored while full.
  assign pop  = out_valid_o & out_ready_i;

  always_comb
  begin
    count_n = count_q;
    if (push & ~pop)
    begin
      count_n = count_q + 1'b1;
    end
    else if (pop & ~push)
    begin
      count_n = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      full_o   <= 1'b0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_q <= (wr_ptr_q == ptr_w_lp'(depth_p - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop)
      begin
        rd_ptr_q <= (rd_ptr_q == ptr_w_lp'(depth_p - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_n;
      full_o  <= count_n == cnt_w_lp'(depth_p);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      mem[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/exec_slice_top.sv
`timescale 1ns/10ps
`default_nettype none

module exec_slice_top #(
  parameter int fifo_depth_p = 2
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              in_valid_i,
  input  core_pkg::instr_t  in_instr_i,
  output logic              in_ready_o,
  output logic              out_valid_o,
  output core_pkg::result_t out_result_o,
  input  logic              out_ready_i
);

  import core_pkg::*;

  logic                         stage_free;
  logic                         issue_valid;
  instr_t                       issue_instr;
  rf_read_t [1:0]               rd_port;
  logic [1:0][data_width_c-1:0] rs_data;
  rf_write_t                    wr;
  logic                         push;
  result_t                      result;
  logic                         fifo_full;

  issue_stage issue0 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .in_valid_i    (in_valid_i),
    .in_instr_i    (in_instr_i),
    .stage_free_i  (stage_free),
    .in_ready_o    (in_ready_o),
    .rd_port_o     (rd_port),
    .issue_valid_o (issue_valid),
    .issue_instr_o (issue_instr)
  );

  regfile regfile0 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .rd_port_i (rd_port),
    .wr_i      (wr),
    .rs_data_o (rs_data)
  );

  exec_stage exec0 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid),
    .issue_instr_i (issue_instr),
    .rs_data_i     (rs_data),
    .fifo_full_i   (fifo_full),
    .stage_free_o  (stage_free),
    .wr_o          (wr),
    .push_o        (push),
    .result_o      (result)
  );

  result_fifo #(
    .depth_p (fifo_depth_p)
  ) fifo0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (push),
    .data_i       (result),
    .out_ready_i  (out_ready_i),
    .full_o       (fifo_full),
    .out_valid_o  (out_valid_o),
    .out_result_o (out_result_o)
  );

endmodule

`default_nettype wire

// File: testbench/exec_slice_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module exec_slice_asserts (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              out_valid_i,
  input logic              out_ready_i,
  input core_pkg::result_t out_result_i,
  input logic              in_ready_i,
  input logic              fifo_full_i,
  input logic              stage_valid_i
);

  a_reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !out_valid_i)
    else $error("out_valid_o high during reset");

  // output must not change while it waits for the sink.
  a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_result_i))
    else $error("output changed while stalled");

  a_back_pressure: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fifo_full_i && stage_valid_i |-> !in_ready_i)
    else $error("in_ready_o high with full FIFO and busy stage");

endmodule

bind exec_slice_top exec_slice_asserts asserts0 (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .out_valid_i   (out_valid_o),
  .out_ready_i   (out_ready_i),
  .out_result_i  (out_result_o),
  .in_ready_i    (in_ready_o),
  .fifo_full_i   (fifo_full),
  .stage_valid_i (exec0.valid_q)
);

`default_nettype wire

// File: testbench/tb_exec_slice.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exec_slice;

  import core_pkg::*;

  localparam int clk_period_c     = 8;
  localparam int n_random_c       = 40;
  localparam int chain_len_c      = 40;
  localparam int n_x0_c           = 6;
  localparam int num_instr_c      = rf_depth_c + n_random_c + 2 * chain_len_c + n_x0_c;
  localparam int timeout_cycles_c = num_instr_c * 10 + 100;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    in_valid_i;
  instr_t                  in_instr_i;
  logic                    in_ready_o;
  logic                    out_valid_o;
  result_t                 out_result_o;
  logic                    out_ready_i;
  logic [data_width_c-1:0] model [rf_depth_c]; // architectural register state.
  result_t                 exp_q [$];           // expected results in issue order.
  int                      mismatch_count = 0;
  int                      other_count = 0;
  bit                      random_ready = 1'b0;

  exec_slice_top #(
    .fifo_depth_p (2)
  ) dut0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .in_instr_i   (in_instr_i),
    .in_ready_o   (in_ready_o),
    .out_valid_o  (out_valid_o),
    .out_result_o (out_result_o),
    .out_ready_i  (out_ready_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(clk_period_c / 2) clk_i = ~clk_i;
  end

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp)
    begin
      mismatch_count++;
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  // expected result of one instruction as applied to the model in program order.
  function automatic result_t ref_result(input instr_t ins);
    logic [data_width_c-1:0] imm_ext;
    logic [data_width_c-1:0] a;
    logic [data_width_c-1:0] b;
    logic [data_width_c-1:0] val;
    result_t                 res;
    imm_ext = data_width_c'($signed(ins.imm));
    a = model[ins.rs1];
    b = model[ins.rs2];
    case (ins.opcode)
      op_add:  val = a + b;
      op_sub:  val = a - b;
      op_and:  val = a & b;
      op_xor:  val = a ^ b;
      op_addi: val = a + imm_ext;
      op_li:   val = imm_ext;
      default: val = '0;
    endcase
    if (ins.rd != '0)
    begin
      model[ins.rd] = val; // x0 stays zero.
    end
    res.rd    = ins.rd;
    res.value = val;
    return res;
  endfunction

  function automatic instr_t make_instr(input opcode_e op, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2,
                                        input logic [15:0] imm);
    instr_t ins;
    ins.opcode = op;
    ins.rd     = rd;
    ins.rs1    = rs1;
    ins.rs2    = rs2;
    ins.imm    = imm;
    return ins;
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'($urandom_range(31, 0));
  endfunction

  function automatic opcode_e rand_alu_op();
    return opcode_e'(3'($urandom_range(4, 0))); // any opcode but li.
  endfunction

  // starts on a falling edge and returns on the falling edge after the transfer.
  task automatic send_instr(input instr_t ins);
    in_valid_i = 1'b1;
    in_instr_i = ins;
    while (!in_ready_o)
    begin
      @(negedge clk_i);
    end
    exp_q.push_back(ref_result(ins));
    @(negedge clk_i);
  endtask

  // each instruction reads the rd of the one before it.
  task automatic run_chain(input int len);
    logic [4:0] prev_rd;
    logic [4:0] rd;
    logic [4:0] rs2;
    prev_rd = rand_reg();
    for (int n = 0; n < len; n++)
    begin
      rd  = rand_reg();
      rs2 = ($urandom_range(1, 0) != 0) ? prev_rd : rand_reg();
      send_instr(make_instr(rand_alu_op(), rd, prev_rd, rs2, 16'($urandom)));
      prev_rd = rd;
    end
  endtask

  initial
  begin
    void'($urandom(32'h7d0f521d));
    rst_n_i    = 1'b0;
    in_valid_i = 1'b0;
    in_instr_i = '0;
    for (int r = 0; r < rf_depth_c; r++)
    begin
      model[r] = '0;
    end
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_value(64'(out_valid_o), 64'(1'b0), "out_valid_o after reset");
    check_value(64'(in_ready_o), 64'(1'b1), "in_ready_o after reset");
    for (int r = 0; r < rf_depth_c; r++)
    begin
      send_instr(make_instr(op_li, 5'(r), 5'd0, 5'd0, 16'($urandom)));
    end
    for (int n = 0; n < n_random_c; n++)
    begin
      send_instr(make_instr(rand_alu_op(), rand_reg(), rand_reg(), rand_reg(), 16'($urandom)));
    end
    run_chain(chain_len_c);
    random_ready = 1'b1; // output side now stalls at random.
    run_chain(chain_len_c);
    send_instr(make_instr(op_li, 5'd0, 5'd0, 5'd0, 16'h1234));
    send_instr(make_instr(op_add, 5'd7, 5'd0, 5'd0, 16'h0000));
    send_instr(make_instr(op_addi, 5'd8, 5'd0, 5'd0, 16'hff80));
    send_instr(make_instr(op_addi, 5'd0, 5'd8, 5'd0, 16'h0001));
    send_instr(make_instr(op_sub, 5'd9, 5'd0, 5'd8, 16'h0000));
    send_instr(make_instr(op_add, 5'd11, 5'd8, 5'd0, 16'h0000));
    in_valid_i = 1'b0;
    while (exp_q.size() != 0)
    begin
      @(negedge clk_i);
    end
    repeat (4) @(negedge clk_i);
    check_value(64'(out_valid_o), 64'(1'b0), "out_valid_o after drain");
    finish_run();
  end

  // the output side drives ready and compares every handshake.
  initial
  begin
    result_t expected;
    out_ready_i = 1'b1;
    @(posedge rst_n_i);
    forever
    begin
      @(negedge clk_i);
      out_ready_i = random_ready ? 1'($urandom_range(1, 0)) : 1'b1;
      if (out_valid_o && out_ready_i)
      begin
        if (exp_q.size() == 0)
        begin
          other_count++;
          $display("Error at %0t ns: a result came out with no instruction waiting for it",
                   $time);
        end
        else
        begin
          expected = exp_q.pop_front();
          check_value(64'(out_result_o), 64'(expected), "result");
        end
      end
    end
  end

  initial
  begin
    #(timeout_cycles_c * clk_period_c);
    other_count++;
    $display("Error: the run timed out after %0d cycles", timeout_cycles_c);
    finish_run();
  end

endmodule

`default_nettype wire

// File: list.f
logic/core_pkg.sv
logic/rf_mem_2r1w_sync.sv
logic/regfile.sv
logic/issue_stage.sv
logic/exec_stage.sv
logic/result_fifo.sv
logic/exec_slice_top.sv
testbench/exec_slice_asserts.sv
testbench/tb_exec_slice.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_exec_slice \
  -o sim_exec_slice && ./obj_dir/sim_exec_slice | tee /dev/stderr | grep -q "STATUS: PASS" \
  && echo "simulation passed" || { echo "simulation failed"; exit 1; }
